// File: Bender.yml
package:
  name: rv_exec

sources:
  - include_dirs:
      - src
    files:
      - src/rv_exec_pkg.sv
      - src/alu.sv
      - src/branch_unit.sv
      - src/csr_file.sv
      - src/exec_stage.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - testbench/tb_exec_stage.sv

// File: rv_exec.f
+incdir+src
src/rv_exec_pkg.sv
src/alu.sv
src/branch_unit.sv
src/csr_file.sv
src/exec_stage.sv
testbench/tb_exec_stage.sv

// File: src/alu.sv
/* op2 carries the immediate for I-type and upper-immediate forms
   LUI and AUIPC expect decode to place 0 or pc in op1 */
`include "rv_exec_macros.svh"

module alu
    import rv_exec_pkg::*;
(
    input  xlen_t   op1_i,
    input  xlen_t   op2_i,
    input  opcode_t opcode_i,
    input  pc_t     pc_i,
    output xlen_t   result_o
);

    logic [5:0]  shamt;
    logic [4:0]  shamt_w;
    logic        slt;
    logic        sltu;
    logic [31:0] addw_res;
    logic [31:0] subw_res;
    logic [31:0] sllw_res;
    logic [31:0] srlw_res;
    logic [31:0] sraw_res;
    xlen_t       upper_imm;

    function automatic xlen_t sext_w(input logic [31:0] v);
        return {{(`XLEN-32){v[31]}}, v};
    endfunction

    assign shamt   = op2_i[5:0];
    assign shamt_w = op2_i[4:0];

    assign slt  = $signed(op1_i) < $signed(op2_i);
    assign sltu = op1_i < op2_i;

    // word results before sign extension
    assign addw_res = op1_i[31:0] + op2_i[31:0];
    assign subw_res = op1_i[31:0] - op2_i[31:0];
    assign sllw_res = op1_i[31:0] << shamt_w;
    assign srlw_res = op1_i[31:0] >> shamt_w;
    assign sraw_res = $signed(op1_i[31:0]) >>> shamt_w;

    assign upper_imm = {{(`XLEN-32){op2_i[19]}}, op2_i[19:0], 12'd0};

    always_comb begin
        case (opcode_i)
            `INST_ADDI, `INST_ADD:     result_o = op1_i + op2_i;
            `INST_SUB:                 result_o = op1_i - op2_i;
            `INST_SLTI, `INST_SLT:     result_o = {{(`XLEN-1){1'b0}}, slt};
            `INST_SLTIU, `INST_SLTU:   result_o = {{(`XLEN-1){1'b0}}, sltu};
            `INST_XORI, `INST_XOR:     result_o = op1_i ^ op2_i;
            `INST_ORI, `INST_OR:       result_o = op1_i | op2_i;
            `INST_ANDI, `INST_AND:     result_o = op1_i & op2_i;
            `INST_SLLI, `INST_SLL:     result_o = op1_i << shamt;
            `INST_SRLI, `INST_SRL:     result_o = op1_i >> shamt;
            `INST_SRAI, `INST_SRA:     result_o = $signed(op1_i) >>> shamt;
            `INST_ADDIW, `INST_ADDW:   result_o = sext_w(addw_res);
            `INST_SUBW:                result_o = sext_w(subw_res);
            `INST_SLLIW, `INST_SLLW:   result_o = sext_w(sllw_res);
            `INST_SRLIW, `INST_SRLW:   result_o = sext_w(srlw_res);
            `INST_SRAIW, `INST_SRAW:   result_o = sext_w(sraw_res);
            `INST_LUI, `INST_AUIPC:    result_o = op1_i + upper_imm;
            // link address
            `INST_JAL, `INST_JALR:     result_o = pc_i + xlen_t'(4);
            `INST_EBREAK:              result_o = op1_i;
            default:                   result_o = '0;
        endcase
    end

endmodule

// File: src/branch_unit.sv
/* fetch always predicts taken, so only a false condition is reported
   non-branch codes never mispredict */
`include "rv_exec_macros.svh"

module branch_unit
    import rv_exec_pkg::*;
(
    input  xlen_t   op1_i,
    input  xlen_t   op2_i,
    input  opcode_t opcode_i,
    input  logic    is_branch_i,
    output logic    mispredict_o
);

    logic lt_s;
    logic lt_u;
    logic cond_true;

    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;

    always_comb begin
        case (opcode_i)
            `INST_BEQ:  cond_true = op1_i == op2_i;
            `INST_BNE:  cond_true = op1_i != op2_i;
            `INST_BLT:  cond_true = lt_s;
            `INST_BGE:  cond_true = ~lt_s;
            `INST_BLTU: cond_true = lt_u;
            `INST_BGEU: cond_true = ~lt_u;
            default:    cond_true = 1'b1;
        endcase
    end

    assign mispredict_o = is_branch_i & ~cond_true;

endmodule

// File: src/csr_file.sv
/* machine-mode CSRs only; all state holds while stall_i is high
   a timer trap takes priority over ECALL, MRET and CSR writes */
`include "rv_exec_macros.svh"

module csr_file
    import rv_exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      stall_i,
    input  pc_t       pc_i,
    input  logic      rd_en_i,
    input  logic      wr_en_i,
    input  csr_addr_t addr_i,
    input  xlen_t     wdata_i,
    input  logic      ecall_i,
    input  logic      mret_i,
    input  logic      timer_intr_i,
    output xlen_t     rdata_o,
    output pc_t       redirect_pc_o,
    output logic      timer_trap_o
);

    localparam xlen_t ECALL_CAUSE = xlen_t'(11);
    localparam xlen_t TIMER_CAUSE = {1'b1, {(`XLEN-5){1'b0}}, 4'd7};

    xlen_t mstatus;
    xlen_t mie;
    xlen_t mtvec;
    xlen_t mscratch;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t csr_value;
    logic  trap;

    assign timer_trap_o = timer_intr_i & mstatus[`MSTATUS_MIE] & mie[`MIE_MTIE];
    assign trap         = ecall_i | timer_trap_o;

    always_comb begin
        case (addr_i)
            `CSR_MSTATUS:  csr_value = mstatus;
            `CSR_MIE:      csr_value = mie;
            `CSR_MTVEC:    csr_value = mtvec;
            `CSR_MSCRATCH: csr_value = mscratch;
            `CSR_MEPC:     csr_value = mepc;
            `CSR_MCAUSE:   csr_value = mcause;
            default:       csr_value = '0;
        endcase
    end

    assign rdata_o = rd_en_i ? csr_value : '0;

    // trap goes to the handler, mret back to the saved pc
    assign redirect_pc_o = trap   ? mtvec :
                           mret_i ? mepc  : '0;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (!stall_i) begin
            if (trap) begin
                mepc                   <= pc_i;
                mcause                 <= timer_trap_o ? TIMER_CAUSE : ECALL_CAUSE;
                mstatus[`MSTATUS_MPIE] <= mstatus[`MSTATUS_MIE];
                mstatus[`MSTATUS_MIE]  <= 1'b0;
            end else if (mret_i) begin
                mstatus[`MSTATUS_MIE]  <= mstatus[`MSTATUS_MPIE];
                mstatus[`MSTATUS_MPIE] <= 1'b1;
            end else if (wr_en_i) begin
                case (addr_i)
                    `CSR_MSTATUS:  mstatus  <= wdata_i;
                    `CSR_MIE:      mie      <= wdata_i;
                    `CSR_MTVEC:    mtvec    <= wdata_i;
                    `CSR_MSCRATCH: mscratch <= wdata_i;
                    `CSR_MEPC:     mepc     <= wdata_i;
                    `CSR_MCAUSE:   mcause   <= wdata_i;
                    default:       ;
                endcase
            end
        end
    end

endmodule

// File: src/exec_stage.sv
/* fully combinational except for the CSR file; CSR address is op2[11:0]
   immediate CSR forms expect the zero-extended zimm in op1 */
`include "rv_exec_macros.svh"

module exec_stage
    import rv_exec_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  pc_t        pc_i,
    input  inst_t      inst_i,
    input  inst_type_t inst_type_i,
    input  opcode_t    opcode_i,
    input  xlen_t      op1_i,
    input  xlen_t      op2_i,
    input  logic       rd_ena_i,
    input  reg_addr_t  rd_addr_i,
    input  ls_sel_t    ls_sel_i,
    input  logic [11:0] addr_offset_i,
    input  logic       if_stall_req_i,
    input  logic       ex_stall_i,
    input  logic       timer_intr_i,
    output inst_type_t inst_type_o,
    output logic       rd_ena_o,
    output reg_addr_t  rd_addr_o,
    output xlen_t      rd_data_o,
    output pc_t        ex_pc_o,
    output inst_t      ex_inst_o,
    output ls_sel_t    ls_sel_o,
    output xlen_t      ls_addr_o,
    output logic       flush_o,
    output logic       redirect_o,
    output pc_t        redirect_pc_o,
    output logic       ex_stall_req_o
);

    xlen_t     alu_result;
    logic      mispredict;
    logic      csr_op;
    logic      csr_rd_en;
    logic      csr_wr_en;
    csr_addr_t csr_addr;
    xlen_t     csr_wdata;
    xlen_t     csr_rdata;
    logic      ecall_en;
    logic      mret_en;
    pc_t       csr_redirect_pc;
    logic      timer_trap;
    logic      csr_redirect;

    alu i_alu (
        .op1_i    (op1_i),
        .op2_i    (op2_i),
        .opcode_i (opcode_i),
        .pc_i     (pc_i),
        .result_o (alu_result)
    );

    branch_unit i_branch_unit (
        .op1_i        (op1_i),
        .op2_i        (op2_i),
        .opcode_i     (opcode_i),
        .is_branch_i  (inst_type_i[`IT_BRANCH]),
        .mispredict_o (mispredict)
    );

    assign csr_addr = op2_i[11:0];

    // system op decode; S/C forms skip the write when the mask is zero
    always_comb begin
        csr_op    = 1'b0;
        csr_rd_en = 1'b0;
        csr_wr_en = 1'b0;
        ecall_en  = 1'b0;
        mret_en   = 1'b0;
        if (inst_type_i[`IT_SYSTEM]) begin
            case (opcode_i)
                `INST_CSRRW, `INST_CSRRWI: begin
                    csr_op    = 1'b1;
                    csr_rd_en = rd_addr_i != '0;
                    csr_wr_en = 1'b1;
                end
                `INST_CSRRS, `INST_CSRRSI: begin
                    csr_op    = 1'b1;
                    csr_rd_en = 1'b1;
                    csr_wr_en = op1_i != '0;
                end
                `INST_CSRRC, `INST_CSRRCI: begin
                    csr_op    = 1'b1;
                    csr_rd_en = 1'b1;
                    csr_wr_en = op1_i != '0;
                end
                `INST_ECALL: ecall_en = 1'b1;
                `INST_MRET:  mret_en  = 1'b1;
                default:     ;
            endcase
        end
    end

    // write value, S/C forms merge the mask into the old value
    always_comb begin
        case (opcode_i)
            `INST_CSRRS, `INST_CSRRSI: csr_wdata = csr_rdata | op1_i;
            `INST_CSRRC, `INST_CSRRCI: csr_wdata = csr_rdata & ~op1_i;
            default:                   csr_wdata = op1_i;
        endcase
    end

    csr_file i_csr_file (
        .clk           (clk),
        .reset_i       (reset_i),
        .stall_i       (ex_stall_i),
        .pc_i          (pc_i),
        .rd_en_i       (csr_rd_en),
        .wr_en_i       (csr_wr_en),
        .addr_i        (csr_addr),
        .wdata_i       (csr_wdata),
        .ecall_i       (ecall_en),
        .mret_i        (mret_en),
        .timer_intr_i  (timer_intr_i),
        .rdata_o       (csr_rdata),
        .redirect_pc_o (csr_redirect_pc),
        .timer_trap_o  (timer_trap)
    );

    assign rd_data_o = inst_type_i[`IT_STORE] ? op2_i     :
                       csr_op                 ? csr_rdata : alu_result;

    // timer trap squashes the instruction in the stage
    assign inst_type_o = inst_type_i & {8{~timer_trap}};
    assign rd_ena_o    = rd_ena_i & ~timer_trap;
    assign rd_addr_o   = rd_addr_i;
    assign ex_pc_o     = pc_i;
    assign ex_inst_o   = inst_i;

    assign ls_sel_o  = ls_sel_i;
    assign ls_addr_o = (inst_type_i[`IT_LOAD] | inst_type_i[`IT_STORE]) ?
                       op1_i + {{(`XLEN-12){addr_offset_i[11]}}, addr_offset_i} : '0;

    assign csr_redirect   = ecall_en | mret_en | timer_trap;
    assign redirect_o     = mispredict | csr_redirect;
    assign redirect_pc_o  = csr_redirect ? csr_redirect_pc : pc_i + pc_t'(4);
    assign flush_o        = redirect_o;
    // hold the stage while fetch finishes its outstanding request
    assign ex_stall_req_o = redirect_o & if_stall_req_i;

endmodule

// File: src/rv_exec_macros.svh
/* opcode codes are internal to this core and match what decode emits
   any CSR address not listed here reads zero and ignores writes */
`ifndef RV_EXEC_MACROS_SVH
`define RV_EXEC_MACROS_SVH

`define XLEN 64

// one-hot instruction class bits
`define IT_STORE  0
`define IT_LOAD   1
`define IT_BRANCH 2
`define IT_SYSTEM 7

// integer register-immediate and register-register
`define INST_ADDI   8'h01
`define INST_SLTI   8'h02
`define INST_SLTIU  8'h03
`define INST_XORI   8'h04
`define INST_ORI    8'h05
`define INST_ANDI   8'h06
`define INST_SLLI   8'h07
`define INST_SRLI   8'h08
`define INST_SRAI   8'h09
`define INST_ADD    8'h0a
`define INST_SUB    8'h0b
`define INST_SLL    8'h0c
`define INST_SLT    8'h0d
`define INST_SLTU   8'h0e
`define INST_XOR    8'h0f
`define INST_SRL    8'h10
`define INST_SRA    8'h11
`define INST_OR     8'h12
`define INST_AND    8'h13

// 32-bit word ops
`define INST_ADDIW  8'h14
`define INST_SLLIW  8'h15
`define INST_SRLIW  8'h16
`define INST_SRAIW  8'h17
`define INST_ADDW   8'h18
`define INST_SUBW   8'h19
`define INST_SLLW   8'h1a
`define INST_SRLW   8'h1b
`define INST_SRAW   8'h1c

`define INST_BEQ    8'h20
`define INST_BNE    8'h21
`define INST_BLT    8'h22
`define INST_BGE    8'h23
`define INST_BLTU   8'h24
`define INST_BGEU   8'h25

`define INST_CSRRW  8'h30
`define INST_CSRRS  8'h31
`define INST_CSRRC  8'h32
`define INST_CSRRWI 8'h33
`define INST_CSRRSI 8'h34
`define INST_CSRRCI 8'h35
`define INST_ECALL  8'h36
`define INST_MRET   8'h37
`define INST_EBREAK 8'h38

`define INST_LUI    8'h40
`define INST_AUIPC  8'h41
`define INST_JAL    8'h42
`define INST_JALR   8'h43

`define CSR_MSTATUS  12'h300
`define CSR_MIE      12'h304
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342

`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7
`define MIE_MTIE     7

`endif

// File: src/rv_exec_pkg.sv
/* shared vector types for the execute stage
   widths follow XLEN from the macros header */
`include "rv_exec_macros.svh"

package rv_exec_pkg;

    // register data and pc
    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [`XLEN-1:0] pc_t;

    // raw 32-bit instruction word
    typedef logic [31:0] inst_t;

    // register and csr indices
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;

    // one-hot class, see IT_* bits
    typedef logic [7:0] inst_type_t;

    // internal INST_* code
    typedef logic [7:0] opcode_t;

    // load/store size and sign
    typedef logic [2:0] ls_sel_t;

endpackage

// File: testbench/tb_exec_stage.sv
/* rows run back to back, so each CSR row depends on the state left by earlier rows
   inputs change 2 ns after a rising edge and outputs are sampled 2.5 ns before the next */
`include "rv_exec_macros.svh"

module tb_exec_stage
    import rv_exec_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam inst_type_t T_ALU    = 8'h00;
    localparam inst_type_t T_STORE  = 8'h01 << `IT_STORE;
    localparam inst_type_t T_LOAD   = 8'h01 << `IT_LOAD;
    localparam inst_type_t T_BRANCH = 8'h01 << `IT_BRANCH;
    localparam inst_type_t T_SYS    = 8'h01 << `IT_SYSTEM;
    localparam pc_t        PC0      = 64'h1000;

    typedef struct {
        string      name;
        inst_type_t itype;
        opcode_t    opc;
        xlen_t      op1;
        xlen_t      op2;
        pc_t        pc;
        reg_addr_t  rd;
        logic [11:0] off;
        logic       tmr;
        logic       stall;
        logic       ifreq;
        xlen_t      e_data;
        logic       e_ena;
        logic       e_redir;
        pc_t        e_rpc;
        xlen_t      e_ls;
    } row_t;

    logic        clk = 1'b0;
    logic        reset_i;
    pc_t         pc_i;
    inst_t       inst_i;
    inst_type_t  inst_type_i;
    opcode_t     opcode_i;
    xlen_t       op1_i;
    xlen_t       op2_i;
    logic        rd_ena_i;
    reg_addr_t   rd_addr_i;
    ls_sel_t     ls_sel_i;
    logic [11:0] addr_offset_i;
    logic        if_stall_req_i;
    logic        ex_stall_i;
    logic        timer_intr_i;
    inst_type_t  inst_type_o;
    logic        rd_ena_o;
    reg_addr_t   rd_addr_o;
    xlen_t       rd_data_o;
    pc_t         ex_pc_o;
    inst_t       ex_inst_o;
    ls_sel_t     ls_sel_o;
    xlen_t       ls_addr_o;
    logic        flush_o;
    logic        redirect_o;
    pc_t         redirect_pc_o;
    logic        ex_stall_req_o;

    row_t   rows[$];
    integer seed = 45;
    int     errors = 0;
    int     passed = 0;
    int     failed = 0;
    bit     row_ok;
    bit     timed_out = 1'b0;

    always #20 clk = ~clk;

    exec_stage i_exec_stage (
        .clk            (clk),
        .reset_i        (reset_i),
        .pc_i           (pc_i),
        .inst_i         (inst_i),
        .inst_type_i    (inst_type_i),
        .opcode_i       (opcode_i),
        .op1_i          (op1_i),
        .op2_i          (op2_i),
        .rd_ena_i       (rd_ena_i),
        .rd_addr_i      (rd_addr_i),
        .ls_sel_i       (ls_sel_i),
        .addr_offset_i  (addr_offset_i),
        .if_stall_req_i (if_stall_req_i),
        .ex_stall_i     (ex_stall_i),
        .timer_intr_i   (timer_intr_i),
        .inst_type_o    (inst_type_o),
        .rd_ena_o       (rd_ena_o),
        .rd_addr_o      (rd_addr_o),
        .rd_data_o      (rd_data_o),
        .ex_pc_o        (ex_pc_o),
        .ex_inst_o      (ex_inst_o),
        .ls_sel_o       (ls_sel_o),
        .ls_addr_o      (ls_addr_o),
        .flush_o        (flush_o),
        .redirect_o     (redirect_o),
        .redirect_pc_o  (redirect_pc_o),
        .ex_stall_req_o (ex_stall_req_o)
    );

    task automatic add_row(
        input string name, input inst_type_t itype, input opcode_t opc,
        input xlen_t op1, input xlen_t op2, input pc_t pc, input reg_addr_t rd,
        input logic [11:0] off, input logic tmr, input logic stall, input logic ifreq,
        input xlen_t e_data, input logic e_ena, input logic e_redir, input pc_t e_rpc,
        input xlen_t e_ls
    );
        row_t r;
        r.name    = name;
        r.itype   = itype;
        r.opc     = opc;
        r.op1     = op1;
        r.op2     = op2;
        r.pc      = pc;
        r.rd      = rd;
        r.off     = off;
        r.tmr     = tmr;
        r.stall   = stall;
        r.ifreq   = ifreq;
        r.e_data  = e_data;
        r.e_ena   = e_ena;
        r.e_redir = e_redir;
        r.e_rpc   = e_rpc;
        r.e_ls    = e_ls;
        rows.push_back(r);
    endtask

    task automatic add_alu(input string name, input opcode_t opc,
                           input xlen_t a, input xlen_t b, input xlen_t exp);
        add_row(name, T_ALU, opc, a, b, PC0, 5'd1, 12'd0, 0, 0, 0, exp, 1, 0, '0, '0);
    endtask

    // fetch already went to the target, a false condition redirects to pc+4
    task automatic add_branch(input string name, input opcode_t opc,
                              input xlen_t a, input xlen_t b, input logic taken);
        add_row(name, T_BRANCH, opc, a, b, PC0, 5'd0, 12'd0, 0, 0, 0, '0, 0, !taken,
                PC0 + 4, '0);
    endtask

    // csr address travels in op2
    task automatic add_csr(input string name, input opcode_t opc, input csr_addr_t csr,
                           input xlen_t a, input reg_addr_t rd, input logic stall,
                           input xlen_t exp);
        add_row(name, T_SYS, opc, a, xlen_t'(csr), PC0, rd, 12'd0, 0, stall, 0, exp,
                rd != 5'd0, 0, '0, '0);
    endtask

    task automatic build_table();
        xlen_t a;
        xlen_t b;
        add_alu("slt_mixed_sign", `INST_SLT, -64'sd5, 64'd3, 64'd1);
        add_alu("slt_pos_vs_neg", `INST_SLT, 64'd3, -64'sd5, 64'd0);
        add_alu("sra_negative", `INST_SRA, 64'h8000_0000_0000_0000, 64'd4,
                64'hf800_0000_0000_0000);
        add_alu("addw_overflow", `INST_ADDW, 64'h7fff_ffff, 64'd1, 64'hffff_ffff_8000_0000);
        add_alu("subw_negative", `INST_SUBW, 64'd0, 64'd1, 64'hffff_ffff_ffff_ffff);
        add_alu("sraw_negative", `INST_SRAW, 64'h0000_0001_8000_0000, 64'd4,
                64'hffff_ffff_f800_0000);
        for (int k = 0; k < 2; k++) begin
            a = {$random(seed), $random(seed)};
            b = {$random(seed), $random(seed)};
            add_alu($sformatf("rand_add_%0d", k), `INST_ADD, a, b, a + b);
            add_alu($sformatf("rand_sub_%0d", k), `INST_SUB, a, b, a - b);
            add_alu($sformatf("rand_xor_%0d", k), `INST_XOR, a, b, a ^ b);
            add_alu($sformatf("rand_or_%0d", k), `INST_OR, a, b, a | b);
            add_alu($sformatf("rand_and_%0d", k), `INST_AND, a, b, a & b);
            add_alu($sformatf("rand_sltu_%0d", k), `INST_SLTU, a, b, (a < b) ? 64'd1 : 64'd0);
        end
        add_branch("beq_taken", `INST_BEQ, 64'd5, 64'd5, 1);
        add_branch("beq_not_taken", `INST_BEQ, 64'd5, 64'd6, 0);
        add_branch("bne_taken", `INST_BNE, 64'd5, 64'd6, 1);
        add_branch("bne_not_taken", `INST_BNE, 64'd5, 64'd5, 0);
        add_branch("blt_taken", `INST_BLT, -64'sd1, 64'd1, 1);
        add_branch("blt_not_taken", `INST_BLT, 64'd1, -64'sd1, 0);
        add_branch("bge_taken", `INST_BGE, 64'd1, -64'sd1, 1);
        add_branch("bge_not_taken", `INST_BGE, -64'sd1, 64'd1, 0);
        add_branch("bltu_taken", `INST_BLTU, 64'd1, -64'sd1, 1);
        add_branch("bltu_not_taken", `INST_BLTU, -64'sd1, 64'd1, 0);
        add_branch("bgeu_taken", `INST_BGEU, -64'sd1, 64'd1, 1);
        add_branch("bgeu_not_taken", `INST_BGEU, 64'd1, -64'sd1, 0);
        add_row("load_neg_offset", T_LOAD, 8'h00, 64'h2000, 64'd0, PC0, 5'd3, 12'hff0,
                0, 0, 0, '0, 1, 0, '0, 64'h1ff0);
        add_row("store_neg_offset", T_STORE, 8'h00, 64'h3000, 64'hdead_beef_cafe_f00d, PC0,
                5'd0, 12'h800, 0, 0, 0, 64'hdead_beef_cafe_f00d, 0, 0, '0, 64'h2800);
        add_row("non_mem_addr", T_ALU, `INST_ADD, 64'h10, 64'h20, PC0, 5'd1, 12'h004,
                0, 0, 0, 64'h30, 1, 0, '0, '0);
        add_csr("csrrw_mscratch", `INST_CSRRW, `CSR_MSCRATCH, 64'ha5, 5'd1, 0, 64'h0);
        add_csr("csrrs_mscratch", `INST_CSRRS, `CSR_MSCRATCH, 64'h0f00, 5'd2, 0, 64'ha5);
        add_csr("csrrc_mscratch", `INST_CSRRC, `CSR_MSCRATCH, 64'h00a0, 5'd3, 0, 64'h0fa5);
        add_csr("csrrs_zero_mask", `INST_CSRRS, `CSR_MSCRATCH, 64'h0, 5'd4, 0, 64'h0f05);
        add_csr("csrrw_stalled", `INST_CSRRW, `CSR_MSCRATCH, 64'h1234, 5'd5, 1, 64'h0f05);
        add_csr("mscratch_kept", `INST_CSRRS, `CSR_MSCRATCH, 64'h0, 5'd6, 0, 64'h0f05);
        add_csr("write_mtvec", `INST_CSRRW, `CSR_MTVEC, 64'h8000, 5'd0, 0, 64'h0);
        add_row("ecall", T_SYS, `INST_ECALL, 64'd0, 64'd0, 64'h4000, 5'd0, 12'd0,
                0, 0, 0, '0, 0, 1, 64'h8000, '0);
        add_csr("read_mepc", `INST_CSRRS, `CSR_MEPC, 64'h0, 5'd1, 0, 64'h4000);
        add_csr("read_mcause_ecall", `INST_CSRRS, `CSR_MCAUSE, 64'h0, 5'd1, 0, 64'd11);
        add_row("mret", T_SYS, `INST_MRET, 64'd0, 64'd0, 64'h8010, 5'd0, 12'd0,
                0, 0, 0, '0, 0, 1, 64'h4000, '0);
        add_csr("write_mie_mtie", `INST_CSRRW, `CSR_MIE, 64'h80, 5'd0, 0, 64'h0);
        // global enable still clear after mret
        add_row("timer_mie_clear", T_ALU, `INST_ADD, 64'd1, 64'd2, 64'h5000, 5'd7, 12'd0,
                1, 0, 0, 64'd3, 1, 0, '0, '0);
        add_csr("set_mstatus_mie", `INST_CSRRS, `CSR_MSTATUS, 64'h8, 5'd1, 0, 64'h80);
        add_row("timer_trap", T_ALU, `INST_ADD, 64'd1, 64'd2, 64'h5000, 5'd7, 12'd0,
                1, 0, 1, 64'd3, 0, 1, 64'h8000, '0);
        add_csr("read_mcause_timer", `INST_CSRRS, `CSR_MCAUSE, 64'h0, 5'd1, 0,
                64'h8000_0000_0000_0007);
        add_csr("read_mepc_timer", `INST_CSRRS, `CSR_MEPC, 64'h0, 5'd1, 0, 64'h5000);
        add_row("if_req_no_redirect", T_ALU, `INST_ADD, 64'd4, 64'd5, PC0, 5'd1, 12'd0,
                0, 0, 1, 64'd9, 1, 0, '0, '0);
    endtask

    // instruction word carried along with each row
    function automatic inst_t encode_inst(input row_t r);
        return {r.opc, 12'h000, r.rd, 7'h13};
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("ERROR %s %s expected %h actual %h", test, field, exp, act);
            errors++;
            row_ok = 1'b0;
        end
    endtask

    // polls in 1 ns steps so a stopped clock cannot hang the run
    task automatic wait_rise(output bit ok);
        logic last;
        int   steps;
        last  = clk;
        ok    = 1'b0;
        steps = 0;
        while (!ok && steps < 100) begin
            #1;
            steps++;
            if (last === 1'b0 && clk === 1'b1) ok = 1'b1;
            last = clk;
        end
        if (!ok) $display("timeout, no rising clock edge seen within 100 ns");
    endtask

    task automatic apply_row(input row_t r);
        pc_i           = r.pc;
        inst_i         = encode_inst(r);
        inst_type_i    = r.itype;
        opcode_i       = r.opc;
        op1_i          = r.op1;
        op2_i          = r.op2;
        rd_ena_i       = r.rd != 5'd0;
        rd_addr_i      = r.rd;
        ls_sel_i       = ls_sel_t'(r.rd);
        addr_offset_i  = r.off;
        timer_intr_i   = r.tmr;
        ex_stall_i     = r.stall;
        if_stall_req_i = r.ifreq;
    endtask

    task automatic check_row(input row_t r);
        inst_type_t exp_type;
        // a taken timer trap clears the class bits
        exp_type = (r.tmr && r.e_redir) ? 8'h00 : r.itype;
        row_ok = 1'b1;
        check_value(r.name, "rd_data", r.e_data, rd_data_o);
        check_value(r.name, "rd_ena", r.e_ena, rd_ena_o);
        check_value(r.name, "rd_addr", r.rd, rd_addr_o);
        check_value(r.name, "inst_type", exp_type, inst_type_o);
        check_value(r.name, "redirect", r.e_redir, redirect_o);
        check_value(r.name, "flush", r.e_redir, flush_o);
        if (r.e_redir) check_value(r.name, "redirect_pc", r.e_rpc, redirect_pc_o);
        check_value(r.name, "ls_addr", r.e_ls, ls_addr_o);
        check_value(r.name, "ls_sel", ls_sel_t'(r.rd), ls_sel_o);
        check_value(r.name, "ex_stall_req", r.e_redir & r.ifreq, ex_stall_req_o);
        check_value(r.name, "ex_pc", r.pc, ex_pc_o);
        check_value(r.name, "ex_inst", encode_inst(r), ex_inst_o);
        if (row_ok) begin
            passed++;
            $display("ok   %s", r.name);
        end else begin
            failed++;
            $display("bad  %s", r.name);
        end
    endtask

    initial begin
        bit ok;
        reset_i = 1'b1;
        apply_row('{name: "idle", default: '0});
        build_table();
        // keep the polling half a step away from the clock transitions
        #0.5;
        for (int i = 0; i < 10 && !timed_out; i++) begin
            wait_rise(ok);
            if (!ok) timed_out = 1'b1;
        end
        #1.5 reset_i = 1'b0;
        foreach (rows[i]) begin
            if (timed_out) break;
            wait_rise(ok);
            if (!ok) begin
                timed_out = 1'b1;
            end else begin
                #1.5 apply_row(rows[i]);
                #35.5 check_row(rows[i]);
            end
        end
        $display("%0d tests, %0d ok, %0d bad, %0d mismatches", rows.size(), passed, failed,
                 errors);
        if (errors == 0 && !timed_out && passed == rows.size())
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
